// ==== common/simmem_cfg_pkg.sv ====
// Response bank sizes

package simmem_cfg_pkg;

  // Transaction identifiers
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // Shared slot pool
  localparam int unsigned Capacity = 8;
  localparam int unsigned SlotWidth = 3;

  // Payload of one write response
  localparam int unsigned PayloadWidth = 16;

  // Per-list counters must hold the value Capacity itself
  localparam int unsigned CountWidth = 4;

endpackage

// ==== common/simmem_types_pkg.sv ====
// Response bank types

package simmem_types_pkg;

  import simmem_cfg_pkg::*;

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotWidth-1:0] slot_t;
  typedef logic [Capacity-1:0] slot_mask_t;
  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [CountWidth-1:0] count_t;

  // Response as seen on the bank ports
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

  // Message memory write
  typedef struct packed {
    logic     en;
    slot_t    slot;
    payload_t data;
  } mem_wr_t;

  // Pointer memory write, slot points to next
  typedef struct packed {
    logic  en;
    slot_t slot;
    slot_t next;
  } link_wr_t;

endpackage

// ==== logic/slot_ram.sv ====
// Slot indexed register memory

`timescale 1ns/10ps

module slot_ram import simmem_cfg_pkg::*, simmem_types_pkg::*; #(
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   wr_en_i,
  input  slot_t  wr_slot_i,
  input  entry_t wr_data_i,
  input  slot_t  rd_slot_i,
  output entry_t rd_data_o
);

  entry_t mem_q [Capacity];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (wr_en_i) begin
      mem_q[wr_slot_i] <= wr_data_i;
    end
  end

  // Combinational read, a same-cycle write shows up next cycle
  assign rd_data_o = mem_q[rd_slot_i];

endmodule

// ==== logic/slot_allocator.sv ====
// Slot pool occupancy

`timescale 1ns/10ps

module slot_allocator import simmem_cfg_pkg::*, simmem_types_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       res_valid_i,
  output logic       res_ready_o,
  output logic       res_fire_o,
  output slot_t      free_slot_o,
  input  slot_mask_t freed_i
);

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_mask_t set_mask;

  // Priority chain, lowest free slot wins
  always_comb begin
    free_slot_o = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        free_slot_o = slot_t'(i);
      end
    end
  end

  assign res_ready_o = ~&occ_q;
  assign res_fire_o = res_valid_i && res_ready_o;

  assign set_mask = res_fire_o ? slot_mask_t'(1) << free_slot_o : '0;

  // Reserved slots are never freed on the same edge
  assign occ_d = (occ_q | set_mask) & ~freed_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// ==== lists/list_ctrl.sv ====
// Per-identifier linked lists

`timescale 1ns/10ps

module list_ctrl import simmem_cfg_pkg::*, simmem_types_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      res_fire_i,
  input  id_t                       res_id_i,
  input  slot_t                     free_slot_i,
  input  id_t                       in_msg_id_i,
  input  logic                      store_fire_i,
  output logic                      store_ok_o,
  output slot_t                     store_slot_o,
  input  logic [NumIds-1:0]         fetch_id_i,
  input  logic                      fetch_i,
  output link_wr_t                  link_wr_o,
  output slot_t                     link_rd_slot_o,
  input  slot_t                     link_rd_data_i,
  output slot_t [NumIds-1:0]        tail_slots_o,
  output logic [NumIds-1:0]         filled_o
);

  // Head is newest reserved, fill is oldest unfilled, tail is oldest filled
  slot_t head_q [NumIds];
  slot_t head_d [NumIds];
  slot_t fill_q [NumIds];
  slot_t fill_d [NumIds];
  slot_t tail_q [NumIds];
  slot_t tail_d [NumIds];
  count_t resv_cnt_q [NumIds];
  count_t resv_cnt_d [NumIds];
  count_t fill_cnt_q [NumIds];
  count_t fill_cnt_d [NumIds];

  slot_t fetch_tail;

  always_comb begin
    fetch_tail = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (fetch_id_i[i]) begin
        fetch_tail |= tail_q[i];
      end
    end
  end

  // Fetch owns the pointer read port, stores are held off by the arbiter then
  assign link_rd_slot_o = fetch_i ? fetch_tail : fill_q[in_msg_id_i];

  assign store_ok_o = resv_cnt_q[in_msg_id_i] != '0;
  assign store_slot_o = fill_q[in_msg_id_i];

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      tail_slots_o[i] = tail_q[i];
      filled_o[i] = fill_cnt_q[i] != '0;
    end
  end

  always_comb begin
    head_d = head_q;
    fill_d = fill_q;
    tail_d = tail_q;
    resv_cnt_d = resv_cnt_q;
    fill_cnt_d = fill_cnt_q;
    link_wr_o = '0;

    // Reservation appends the new slot behind the head
    if (res_fire_i) begin
      if (resv_cnt_q[res_id_i] != '0 || fill_cnt_q[res_id_i] != '0) begin
        link_wr_o.en = 1'b1;
        link_wr_o.slot = head_q[res_id_i];
        link_wr_o.next = free_slot_i;
      end
      if (resv_cnt_q[res_id_i] == '0) begin
        fill_d[res_id_i] = free_slot_i;
      end
      head_d[res_id_i] = free_slot_i;
      resv_cnt_d[res_id_i] = resv_cnt_q[res_id_i] + count_t'(1);
    end

    // Store moves the fill pointer along the links
    if (store_fire_i) begin
      if (fill_cnt_q[in_msg_id_i] == '0) begin
        tail_d[in_msg_id_i] = fill_q[in_msg_id_i];
      end
      if (resv_cnt_q[in_msg_id_i] == count_t'(1)) begin
        // Link to a slot reserved right now is still being written
        if (res_fire_i && res_id_i == in_msg_id_i) begin
          fill_d[in_msg_id_i] = free_slot_i;
        end
      end else begin
        fill_d[in_msg_id_i] = link_rd_data_i;
      end
      resv_cnt_d[in_msg_id_i] = resv_cnt_d[in_msg_id_i] - count_t'(1);
      fill_cnt_d[in_msg_id_i] = fill_cnt_q[in_msg_id_i] + count_t'(1);
    end

    // Fetch takes the tail off the list
    for (int i = 0; i < NumIds; i++) begin
      if (fetch_i && fetch_id_i[i]) begin
        tail_d[i] = link_rd_data_i;
        fill_cnt_d[i] = fill_cnt_d[i] - count_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '{default: '0};
      fill_q <= '{default: '0};
      tail_q <= '{default: '0};
      resv_cnt_q <= '{default: '0};
      fill_cnt_q <= '{default: '0};
    end else begin
      head_q <= head_d;
      fill_q <= fill_d;
      tail_q <= tail_d;
      resv_cnt_q <= resv_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

endmodule

// ==== lists/release_sched.sv ====
// Release order and output register

`timescale 1ns/10ps

module release_sched import simmem_cfg_pkg::*, simmem_types_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NumIds-1:0]  filled_i,
  input  slot_t [NumIds-1:0] tail_slots_i,
  input  slot_mask_t         release_en_i,
  output logic               fetch_o,
  output logic [NumIds-1:0]  fetch_id_o,
  output slot_t              fetch_slot_o,
  input  payload_t           rd_payload_i,
  output logic               out_valid_o,
  output msg_t               out_msg_o,
  input  logic               out_ready_i,
  output slot_mask_t         released_o
);

  logic [NumIds-1:0] eligible;
  logic              found;
  id_t               pick_id;
  logic              out_valid_q;
  msg_t              out_msg_q;
  slot_t             out_slot_q;
  logic              handshake;

  for (genvar i = 0; i < NumIds; i++) begin : gen_eligible
    assign eligible[i] = filled_i[i] && release_en_i[tail_slots_i[i]];
  end

  // Lowest eligible identifier
  always_comb begin
    found = 1'b0;
    pick_id = '0;
    fetch_id_o = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (eligible[i] && !found) begin
        found = 1'b1;
        pick_id = id_t'(i);
        fetch_id_o[i] = 1'b1;
      end
    end
  end

  assign handshake = out_valid_q && out_ready_i;
  assign fetch_o = found && (!out_valid_q || out_ready_i);
  assign fetch_slot_o = tail_slots_i[pick_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (fetch_o) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_o) begin
      out_msg_q <= '{id: pick_id, payload: rd_payload_i};
      out_slot_q <= fetch_slot_o;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_msg_o = out_msg_q;
  assign released_o = handshake ? slot_mask_t'(1) << out_slot_q : '0;

endmodule

// ==== logic/msg_port_arbiter.sv ====
// Message memory port arbiter

`timescale 1ns/10ps

module msg_port_arbiter import simmem_types_pkg::*; (
  input  logic    fetch_req_i,
  input  slot_t   fetch_slot_i,
  input  mem_wr_t store_req_i,
  output logic    store_gnt_o,
  output mem_wr_t mem_wr_o,
  output slot_t   mem_rd_slot_o
);

  // Output fetch always wins, input waits while data flows out
  assign store_gnt_o = store_req_i.en && !fetch_req_i;

  always_comb begin
    mem_wr_o = store_req_i;
    mem_wr_o.en = store_gnt_o;
  end

  // One address for the single port
  assign mem_rd_slot_o = fetch_req_i ? fetch_slot_i : store_req_i.slot;

endmodule

// ==== logic/simmem_wr_resp_bank.sv ====
// Write response bank

`timescale 1ns/10ps

module simmem_wr_resp_bank import simmem_cfg_pkg::*, simmem_types_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       res_valid_i,
  input  id_t        res_id_i,
  output logic       res_ready_o,
  output slot_t      res_slot_o,
  input  logic       in_valid_i,
  input  msg_t       in_msg_i,
  output logic       in_ready_o,
  input  slot_mask_t release_en_i,
  output logic       out_valid_o,
  output msg_t       out_msg_o,
  input  logic       out_ready_i,
  output slot_mask_t released_o
);

  logic               res_fire;
  slot_t              free_slot;
  logic               store_ok;
  slot_t              store_slot;
  logic               store_gnt;
  mem_wr_t            store_req;
  mem_wr_t            mem_wr;
  slot_t              mem_rd_slot;
  payload_t           rd_payload;
  logic               fetch;
  logic [NumIds-1:0]  fetch_id;
  slot_t              fetch_slot;
  link_wr_t           link_wr;
  slot_t              link_rd_slot;
  slot_t              link_rd_data;
  slot_t [NumIds-1:0] tail_slots;
  logic [NumIds-1:0]  filled;

  assign res_slot_o = free_slot;
  assign in_ready_o = store_gnt;
  assign store_req = '{en: in_valid_i && store_ok, slot: store_slot, data: in_msg_i.payload};

  slot_allocator i_slot_allocator (
    .clk_i, .rst_ni, .res_valid_i, .res_ready_o,
    .res_fire_o (res_fire), .free_slot_o (free_slot), .freed_i (released_o)
  );

  list_ctrl i_list_ctrl (
    .clk_i, .rst_ni,
    .res_fire_i (res_fire), .res_id_i, .free_slot_i (free_slot),
    .in_msg_id_i (in_msg_i.id), .store_fire_i (store_gnt),
    .store_ok_o (store_ok), .store_slot_o (store_slot),
    .fetch_id_i (fetch_id), .fetch_i (fetch),
    .link_wr_o (link_wr), .link_rd_slot_o (link_rd_slot), .link_rd_data_i (link_rd_data),
    .tail_slots_o (tail_slots), .filled_o (filled)
  );

  release_sched i_release_sched (
    .clk_i, .rst_ni, .filled_i (filled), .tail_slots_i (tail_slots), .release_en_i,
    .fetch_o (fetch), .fetch_id_o (fetch_id), .fetch_slot_o (fetch_slot),
    .rd_payload_i (rd_payload), .out_valid_o, .out_msg_o, .out_ready_i, .released_o
  );

  msg_port_arbiter i_msg_port_arbiter (
    .fetch_req_i (fetch), .fetch_slot_i (fetch_slot), .store_req_i (store_req),
    .store_gnt_o (store_gnt), .mem_wr_o (mem_wr), .mem_rd_slot_o (mem_rd_slot)
  );

  slot_ram #(.entry_t(payload_t)) i_msg_ram (
    .clk_i, .rst_ni, .wr_en_i (mem_wr.en), .wr_slot_i (mem_wr.slot), .wr_data_i (mem_wr.data),
    .rd_slot_i (mem_rd_slot), .rd_data_o (rd_payload)
  );

  slot_ram #(.entry_t(slot_t)) i_link_ram (
    .clk_i, .rst_ni, .wr_en_i (link_wr.en), .wr_slot_i (link_wr.slot), .wr_data_i (link_wr.next),
    .rd_slot_i (link_rd_slot), .rd_data_o (link_rd_data)
  );

endmodule

// ==== sim/tb_clock.sv ====
// Testbench clock and reset

`timescale 1ns/10ps

module tb_clock #(
  parameter int ClkPeriod = 40,
  parameter int ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Reset lets go on a falling edge
  initial begin
    clk_o = 1'b0;
    rst_no = 1'b0;
    #(ResetCycles * ClkPeriod);
    rst_no = 1'b1;
  end

  always #(ClkPeriod / 2) clk_o = ~clk_o;

endmodule

// ==== sim/tb_checks.svh ====
// Result compare tasks

int checks_done = 0;
int errors = 0;

task automatic check_slot(input slot_t got, input slot_t exp, input string what);
  checks_done++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_msg(input msg_t got, input msg_t exp, input string what);
  checks_done++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s is id %0d payload %h, expected id %0d payload %h",
             $time, what, got.id, got.payload, exp.id, exp.payload);
  end
endtask

task automatic check_mask(input slot_mask_t got, input slot_mask_t exp, input string what);
  checks_done++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  checks_done++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

// ==== sim/tb_simmem_wr_resp_bank.sv ====
// Write response bank testbench

`timescale 1ns/10ps

module tb_simmem_wr_resp_bank import simmem_types_pkg::*; ();

  localparam int ClkPeriod = 40;
  localparam int SampleDelay = 5;
  localparam int MaxTests = 64;
  localparam int CyclesPerTest = 200;

  logic       clk_i;
  logic       rst_ni;
  logic       res_valid_i;
  id_t        res_id_i;
  logic       res_ready_o;
  slot_t      res_slot_o;
  logic       in_valid_i;
  msg_t       in_msg_i;
  logic       in_ready_o;
  slot_mask_t release_en_i;
  logic       out_valid_o;
  msg_t       out_msg_o;
  logic       out_ready_i;
  slot_mask_t released_o;

  // Opcode, id, value and mask packed into one word per line
  logic [31:0] tests [MaxTests];
  int          num_tests = 0;
  logic        loaded = 1'b0;
  int          seed = 32'h99b3e8f5;

  `include "tb_checks.svh"

  tb_clock #(.ClkPeriod(ClkPeriod)) i_clock (.clk_o (clk_i), .rst_no (rst_ni));

  simmem_wr_resp_bank dut (.*);

  // Outputs are read in the low phase well after the falling edge drive
  task automatic wait_sample;
    @(negedge clk_i);
    #SampleDelay;
  endtask

  task automatic reserve_slot(input id_t id, input slot_t exp_slot);
    @(negedge clk_i);
    res_valid_i = 1'b1;
    res_id_i = id;
    #SampleDelay;
    while (!res_ready_o) wait_sample();
    check_slot(res_slot_o, exp_slot, "res_slot_o");
    @(negedge clk_i);
    res_valid_i = 1'b0;
  endtask

  task automatic store_msg(input id_t id, input payload_t payload, input logic refused);
    @(negedge clk_i);
    in_valid_i = 1'b1;
    in_msg_i = '{id: id, payload: payload};
    #SampleDelay;
    if (refused) begin
      for (int i = 0; i < 4; i++) begin
        if (i > 0) wait_sample();
        check_flag(in_ready_o, 1'b0, "in_ready_o");
      end
    end else begin
      while (!in_ready_o) wait_sample();
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic pop_msg(input id_t id, input payload_t payload, input slot_mask_t exp_mask);
    msg_t exp_msg;
    exp_msg = '{id: id, payload: payload};
    wait_sample();
    while (!out_valid_o) wait_sample();
    check_msg(out_msg_o, exp_msg, "out_msg_o");
    @(negedge clk_i);
    out_ready_i = 1'b1;
    #SampleDelay;
    check_mask(released_o, exp_mask, "released_o");
    @(negedge clk_i);
    out_ready_i = 1'b0;
  endtask

  task automatic run_test(input int t);
    logic [3:0] op;
    id_t        id;
    payload_t   value;
    slot_mask_t mask;
    int         errors_before;
    string      verdict;
    op = tests[t][31:28];
    id = id_t'(tests[t][27:24]);
    value = tests[t][23:8];
    mask = tests[t][7:0];
    errors_before = errors;
    // Idle gap of up to three cycles
    repeat ($random(seed) & 3) @(negedge clk_i);
    case (op)
      4'h1: reserve_slot(id, slot_t'(value));
      4'h2: store_msg(id, value, 1'b0);
      4'h3: begin
        @(negedge clk_i);
        release_en_i = mask;
      end
      4'h4: pop_msg(id, value, mask);
      4'h5: begin
        wait_sample();
        check_flag(res_ready_o, value[0], "res_ready_o");
      end
      4'h6: store_msg(id, value, 1'b1);
      default: begin
        errors++;
        $display("Test line %0d has an unknown opcode %0h", t, op);
      end
    endcase
    if (errors == errors_before) begin
      verdict = "ok";
    end else begin
      verdict = "failed";
    end
    $display("Test %0d opcode %0h: %s", t, op, verdict);
  endtask

  initial begin : stimulus
    res_valid_i = 1'b0;
    res_id_i = '0;
    in_valid_i = 1'b0;
    in_msg_i = '0;
    release_en_i = '0;
    out_ready_i = 1'b0;
    $readmemh("sim/wr_resp_tests.txt", tests);
    // List ends at the first zero opcode
    while (num_tests < MaxTests && tests[num_tests][31:28] != 4'h0) num_tests++;
    loaded = 1'b1;
    if (num_tests == 0) begin
      errors++;
      $display("No tests could be read from sim/wr_resp_tests.txt");
    end
    wait (rst_ni);
    for (int t = 0; t < num_tests; t++) run_test(t);
    $display("%0d tests, %0d checks, %0d errors", num_tests, checks_done, errors);
    if (errors == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #((num_tests + 1) * CyclesPerTest * ClkPeriod);
    $display("Timeout, the tests did not finish within %0d cycles",
             (num_tests + 1) * CyclesPerTest);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sim/wr_resp_tests.txt ====
// Columns: opcode id value mask. Opcodes 1 reserve (value is expected slot), 2 store,
// 3 set enables, 4 pop (value, mask is released), 5 res_ready check, 6 refused store, 0 end
1_0_0000_00
1_0_0001_00
1_0_0002_00
2_0_1111_00
2_0_2222_00
2_0_3333_00
6_1_aaaa_00
1_1_0003_00
2_1_1001_00
1_2_0004_00
2_2_2002_00
// Only slot 3 enabled, identifier 0 is held back
3_0_0000_08
4_1_1001_08
3_0_0000_ff
4_0_1111_01
4_0_2222_02
4_0_3333_04
4_2_2002_10
// Freed slot 0 comes back first, then the pool fills up
1_3_0000_00
1_0_0001_00
1_1_0002_00
1_2_0003_00
1_3_0004_00
1_0_0005_00
1_1_0006_00
1_2_0007_00
5_0_0000_00
0_0_0000_00

// ==== src.f ====
+incdir+sim
common/simmem_cfg_pkg.sv
common/simmem_types_pkg.sv
logic/slot_ram.sv
logic/slot_allocator.sv
lists/list_ctrl.sv
lists/release_sched.sv
logic/msg_port_arbiter.sv
logic/simmem_wr_resp_bank.sv
sim/tb_clock.sv
sim/tb_simmem_wr_resp_bank.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the response bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module tb_simmem_wr_resp_bank -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/tb_sim); then
  printf '%s\n' "$output"
  echo "Simulation exited with an error"
  exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
